/* gpio_defines.svh */
//------------------------------
// GPIO LED controller parameters
// Bus widths, LED count, field widths and register map
//------------------------------
`ifndef GPIO_DEFINES_SVH
`define GPIO_DEFINES_SVH

// Wishbone bus
`define GPIO_BUS_ADRS_BIT   32
`define GPIO_BUS_DATA_BIT   32

// Block field sits at adr[15:8]
`define GPIO_BLOCK_LSB      8
`define GPIO_BLOCK_MAP_BIT  8
`define GPIO_ADRS_MAP       8'h01
`define GPIO_OFS_BIT        8    // Word offset inside the block

// LED channels
`define GPIO_LED_NUM        5
`define GPIO_MODE_BIT       2
`define GPIO_IVTIMER_BIT    16

// Register offsets
`define GPIO_OFS_EN         8'h00
`define GPIO_OFS_MODE       8'h04
`define GPIO_OFS_IVT0       8'h1C   // IVT1 to IVT4 follow in steps of 4
`define GPIO_OFS_STEP       4

`endif

/* busPkg.sv */
//------------------------------
// Wishbone bus types
// Address, data and byte select words of the slave port
//------------------------------
`default_nettype none

`include "gpio_defines.svh"

package busPkg;

	// Address word
	typedef logic [`GPIO_BUS_ADRS_BIT-1:0] wbAdrs;

	// Data word, used for both directions and for bit masks
	typedef logic [`GPIO_BUS_DATA_BIT-1:0] wbData;

	typedef logic [`GPIO_BUS_DATA_BIT/8-1:0] wbSel;   // One bit per byte lane

endpackage

`default_nettype wire

/* gpioPkg.sv */
//------------------------------
// LED controller types
// LED vector, interval divider and flash modes
//------------------------------
`default_nettype none

`include "gpio_defines.svh"

package gpioPkg;

	typedef logic [`GPIO_LED_NUM-1:0] ledVec;          // One bit per LED
	typedef logic [`GPIO_IVTIMER_BIT-1:0] ivTimer;     // Cycles between ticks, minus one

	// Flash mode shared by all channels
	typedef enum logic [`GPIO_MODE_BIT-1:0]
	{
		modeSteady = 2'd0,   // On while enabled
		modeBlink  = 2'd1,   // Toggles at each tick
		modeStrobe = 2'd2,   // One cycle pulse per tick
		modeOff    = 2'd3    // Dark
	} flashMode;

endpackage

`default_nettype wire

/* wbSlavePort.sv */
//------------------------------
// Wishbone classic slave port
// Turns bus cycles into single cycle register strobes
// and answers each request with one ack or err
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module wbSlavePort
(
	input  wire                iSysClk,
	input  wire                rstN,
	// Wishbone classic
	input  wire                cyc,
	input  wire                stb,
	input  wire                we,
	input  wire busPkg::wbAdrs adr,
	input  wire busPkg::wbSel  sel,
	input  wire busPkg::wbData datW,
	output busPkg::wbData      datR,
	output logic               ack,
	output logic               err,
	// Register block side
	output logic               wrStb,
	output logic               rdStb,
	output busPkg::wbData      wrMask,
	output busPkg::wbAdrs      csrAdrs,
	input  wire busPkg::wbData csrData
);

	logic busy;      // Request already served, wait for stb to drop
	logic newReq;
	logic aligned;

	//------------------------------
	// Request detect
	//------------------------------
	assign aligned = (adr[1:0] == 2'b00);
	assign newReq  = cyc & stb & ~busy;

	// Strobes only for word aligned accesses
	assign wrStb = newReq & aligned & we;
	assign rdStb = newReq & aligned & ~we;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			ack  <= 1'b0;
			err  <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			ack  <= newReq & aligned;    // High for one cycle
			err  <= newReq & ~aligned;
			busy <= cyc & stb;           // Cleared once the master lets go
		end
	end

	//------------------------------
	// Data paths
	//------------------------------
	always_comb
	begin
		for (int i = 0; i < $bits(busPkg::wbSel); i++)
			wrMask[8*i +: 8] = {8{sel[i]}};
	end

	assign csrAdrs = adr;
	assign datR    = csrData;   // Already registered in the CSR block

endmodule

`default_nettype wire

/* gpioCsr.sv */
//------------------------------
// GPIO control and status registers
// Block decode, byte masked writes and registered reads
// Every output to the LED channels comes straight from a register
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module gpioCsr
(
	input  wire                iSysClk,
	input  wire                rstN,
	input  wire                wrStb,
	input  wire                rdStb,
	input  wire busPkg::wbAdrs adrs,
	input  wire busPkg::wbData wrData,
	input  wire busPkg::wbData wrMask,
	output busPkg::wbData      rdData,
	output gpioPkg::ledVec     ledEn,
	output gpioPkg::flashMode  mode,
	output gpioPkg::ivTimer    ivTimer0,
	output gpioPkg::ivTimer    ivTimer1,
	output gpioPkg::ivTimer    ivTimer2,
	output gpioPkg::ivTimer    ivTimer3,
	output gpioPkg::ivTimer    ivTimer4
);

	gpioPkg::ledVec    enReg;
	gpioPkg::flashMode modeReg;
	gpioPkg::ivTimer   ivtReg [`GPIO_LED_NUM];

	logic                     blockHit;
	logic                     enHit;
	logic                     modeHit;
	logic [`GPIO_LED_NUM-1:0] ivtHit;

	busPkg::wbData enMerged;
	busPkg::wbData modeMerged;
	busPkg::wbData ivtMerged [`GPIO_LED_NUM];
	busPkg::wbData rdSel;

	// Keep unselected bytes, take selected ones from the bus
	function automatic busPkg::wbData mergeWord
	(
		input busPkg::wbData oldVal,
		input busPkg::wbData newVal,
		input busPkg::wbData mask
	);
		return (oldVal & ~mask) | (newVal & mask);
	endfunction

	//------------------------------
	// Address decode
	//------------------------------
	always_comb
	begin
		blockHit = (adrs[`GPIO_BLOCK_LSB +: `GPIO_BLOCK_MAP_BIT] == `GPIO_ADRS_MAP);
		enHit    = blockHit && (adrs[`GPIO_OFS_BIT-1:0] == `GPIO_OFS_EN);
		modeHit  = blockHit && (adrs[`GPIO_OFS_BIT-1:0] == `GPIO_OFS_MODE);
		for (int i = 0; i < `GPIO_LED_NUM; i++)
			ivtHit[i] = blockHit && (adrs[`GPIO_OFS_BIT-1:0] ==
				`GPIO_OFS_IVT0 + `GPIO_OFS_BIT'(`GPIO_OFS_STEP * i));
	end

	always_comb
	begin
		enMerged   = mergeWord(busPkg::wbData'(enReg), wrData, wrMask);
		modeMerged = mergeWord(busPkg::wbData'(modeReg), wrData, wrMask);
		for (int i = 0; i < `GPIO_LED_NUM; i++)
			ivtMerged[i] = mergeWord(busPkg::wbData'(ivtReg[i]), wrData, wrMask);
	end

	//------------------------------
	// Register write
	//------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			enReg   <= '0;
			modeReg <= gpioPkg::modeSteady;
			for (int i = 0; i < `GPIO_LED_NUM; i++)
				ivtReg[i] <= '1;   // Slowest interval
		end
		else if (wrStb)
		begin
			if (enHit)
				enReg <= gpioPkg::ledVec'(enMerged);
			if (modeHit)
				modeReg <= gpioPkg::flashMode'(modeMerged[`GPIO_MODE_BIT-1:0]);
			for (int i = 0; i < `GPIO_LED_NUM; i++)
				if (ivtHit[i])
					ivtReg[i] <= gpioPkg::ivTimer'(ivtMerged[i]);
		end
	end

	//------------------------------
	// Register read
	//------------------------------
	always_comb
	begin
		rdSel = '0;   // Unmapped offsets and other blocks read zero
		if (enHit)
			rdSel = busPkg::wbData'(enReg);
		if (modeHit)
			rdSel = busPkg::wbData'(modeReg);
		for (int i = 0; i < `GPIO_LED_NUM; i++)
			if (ivtHit[i])
				rdSel = busPkg::wbData'(ivtReg[i]);
	end

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			rdData <= '0;
		else if (rdStb)
			rdData <= rdSel;   // Valid with ack
	end

	assign ledEn    = enReg;
	assign mode     = modeReg;
	assign ivTimer0 = ivtReg[0];
	assign ivTimer1 = ivtReg[1];
	assign ivTimer2 = ivtReg[2];
	assign ivTimer3 = ivtReg[3];
	assign ivTimer4 = ivtReg[4];

endmodule

`default_nettype wire

/* ledChannel.sv */
//------------------------------
// One LED channel
// Interval divider and flash pattern generator
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module ledChannel
(
	input  wire                    iSysClk,
	input  wire                    rstN,
	input  wire                    en,
	input  wire gpioPkg::flashMode mode,
	input  wire gpioPkg::ivTimer   interval,
	output logic                   led
);

	gpioPkg::ivTimer cnt;
	logic            tick;
	logic            phase;   // Blink level

	// Tick every interval plus one cycles
	assign tick = en && (cnt == '0);

	//------------------------------
	// Interval divider
	//------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cnt   <= '0;
			phase <= 1'b0;
		end
		else if (!en)
		begin
			cnt   <= interval;   // Held until enabled
			phase <= 1'b0;
		end
		else if (tick)
		begin
			cnt   <= interval;   // New interval only lands here
			phase <= ~phase;
		end
		else
			cnt <= cnt - gpioPkg::ivTimer'(1);
	end

	//------------------------------
	// LED level
	//------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			led <= 1'b0;
		else if (!en)
			led <= 1'b0;
		else
			case (mode)
				gpioPkg::modeSteady: led <= 1'b1;
				gpioPkg::modeBlink:  led <= phase ^ tick;   // Follows the new phase
				gpioPkg::modeStrobe: led <= tick;
				default:             led <= 1'b0;
			endcase
	end

endmodule

`default_nettype wire

/* gpioTop.sv */
//------------------------------
// GPIO LED controller top
// Wishbone slave, register block and five LED channels
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module gpioTop
(
	input  wire                iSysClk,
	input  wire                rstN,
	// Wishbone classic slave
	input  wire                cyc,
	input  wire                stb,
	input  wire                we,
	input  wire busPkg::wbAdrs adr,
	input  wire busPkg::wbSel  sel,
	input  wire busPkg::wbData datW,
	output wire busPkg::wbData datR,
	output wire                ack,
	output wire                err,
	// LED pins
	output wire gpioPkg::ledVec led
);

	logic              wrStb;
	logic              rdStb;
	busPkg::wbData     wrMask;
	busPkg::wbAdrs     csrAdrs;
	busPkg::wbData     csrRdData;
	gpioPkg::ledVec    ledEn;
	gpioPkg::flashMode mode;
	gpioPkg::ivTimer   ivt [`GPIO_LED_NUM];

	wbSlavePort uPort
	(
		.iSysClk(iSysClk), .rstN(rstN),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel), .datW(datW),
		.datR(datR), .ack(ack), .err(err),
		.wrStb(wrStb), .rdStb(rdStb), .wrMask(wrMask),
		.csrAdrs(csrAdrs), .csrData(csrRdData)
	);

	gpioCsr uCsr
	(
		.iSysClk(iSysClk), .rstN(rstN),
		.wrStb(wrStb), .rdStb(rdStb), .adrs(csrAdrs),
		.wrData(datW), .wrMask(wrMask), .rdData(csrRdData),
		.ledEn(ledEn), .mode(mode),
		.ivTimer0(ivt[0]), .ivTimer1(ivt[1]), .ivTimer2(ivt[2]),
		.ivTimer3(ivt[3]), .ivTimer4(ivt[4])
	);

	// One channel per LED pin
	for (genvar i = 0; i < `GPIO_LED_NUM; i++)
	begin : gChan
		ledChannel uChan
		(
			.iSysClk(iSysClk), .rstN(rstN),
			.en(ledEn[i]), .mode(mode), .interval(ivt[i]), .led(led[i])
		);
	end

endmodule

`default_nettype wire

/* gpioChecker.sv */
//------------------------------
// GPIO controller monitor
// Shadows the registers and LED channels and compares with the DUT
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module gpioChecker
(
	input  wire                 iSysClk,
	input  wire                 rstN,
	input  wire                 cyc,
	input  wire                 stb,
	input  wire                 we,
	input  wire busPkg::wbAdrs  adr,
	input  wire busPkg::wbSel   sel,
	input  wire busPkg::wbData  datW,
	input  wire busPkg::wbData  datR,
	input  wire                 ack,
	input  wire                 err,
	input  wire gpioPkg::ledVec led,
	output wire [31:0]          errCount
);

	localparam int numRegs = 2 + `GPIO_LED_NUM;   // EN, MODE, dividers

	busPkg::wbData   regM [numRegs];
	gpioPkg::ivTimer ageM [`GPIO_LED_NUM];   // Cycles since last reload
	gpioPkg::ivTimer limM [`GPIO_LED_NUM];   // Interval latched at reload
	gpioPkg::ledVec  phaseM;
	gpioPkg::ledVec  ledM;
	busPkg::wbData   expRd;
	logic            busyM;
	logic            expAck;
	logic            expErr;
	int              errs = 0;

	assign errCount = errs;

	// Register number for an address, -1 when nothing is mapped there
	function automatic int regIndex(input busPkg::wbAdrs a);
		int idx;
		idx = -1;
		if (a[`GPIO_BLOCK_LSB +: `GPIO_BLOCK_MAP_BIT] == `GPIO_ADRS_MAP)
		begin
			if (a[7:0] == `GPIO_OFS_EN)
				idx = 0;
			if (a[7:0] == `GPIO_OFS_MODE)
				idx = 1;
			for (int i = 0; i < `GPIO_LED_NUM; i++)
				if (a[7:0] == 8'(`GPIO_OFS_IVT0 + `GPIO_OFS_STEP * i))
					idx = 2 + i;
		end
		return idx;
	endfunction

	// Implemented bits of each register
	function automatic busPkg::wbData fieldMask(input int idx);
		if (idx == 0)
			return (32'd1 << `GPIO_LED_NUM) - 32'd1;
		else if (idx == 1)
			return (32'd1 << `GPIO_MODE_BIT) - 32'd1;
		return (32'd1 << `GPIO_IVTIMER_BIT) - 32'd1;
	endfunction

	task automatic reportMismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		errs++;
	endtask

	//------------------------------
	// Reference model
	//------------------------------
	always @(posedge iSysClk or negedge rstN)
	begin : modelStep
		logic          newReq;
		logic          tick;
		logic          nextPhase;
		int            idx;
		busPkg::wbData mask;
		if (!rstN)
		begin
			busyM  <= 1'b0;
			expAck <= 1'b0;
			expErr <= 1'b0;
			expRd  <= '0;
			regM[0] <= '0;
			regM[1] <= '0;
			for (int i = 0; i < `GPIO_LED_NUM; i++)
			begin
				regM[2 + i] <= fieldMask(2);   // Dividers come up all ones
				ageM[i] <= '0;
				limM[i] <= '0;
			end
			phaseM <= '0;
			ledM   <= '0;
		end
		else
		begin
			newReq = cyc && stb && !busyM;
			idx = regIndex(adr);
			for (int b = 0; b < 4; b++)
				mask[8*b +: 8] = {8{sel[b]}};
			busyM  <= cyc && stb;
			expAck <= newReq && (adr[1:0] == 2'b00);
			expErr <= newReq && (adr[1:0] != 2'b00);
			if (newReq && (adr[1:0] == 2'b00))
			begin
				if (we && idx >= 0)
					regM[idx] <= ((regM[idx] & ~mask) | (datW & mask)) & fieldMask(idx);
				else if (!we)
					expRd <= (idx >= 0) ? regM[idx] : '0;
			end
			for (int i = 0; i < `GPIO_LED_NUM; i++)
			begin
				tick = regM[0][i] && (ageM[i] == limM[i]);
				nextPhase = phaseM[i] ^ tick;
				if (!regM[0][i])
				begin
					ageM[i]   <= '0;
					limM[i]   <= regM[2 + i][`GPIO_IVTIMER_BIT-1:0];
					phaseM[i] <= 1'b0;
					ledM[i]   <= 1'b0;
				end
				else
				begin
					ageM[i] <= tick ? gpioPkg::ivTimer'(0) : ageM[i] + gpioPkg::ivTimer'(1);
					if (tick)
						limM[i] <= regM[2 + i][`GPIO_IVTIMER_BIT-1:0];   // New interval
					phaseM[i] <= nextPhase;
					case (regM[1][`GPIO_MODE_BIT-1:0])
						gpioPkg::modeSteady: ledM[i] <= 1'b1;
						gpioPkg::modeBlink:  ledM[i] <= nextPhase;
						gpioPkg::modeStrobe: ledM[i] <= tick;
						default:             ledM[i] <= 1'b0;
					endcase
				end
			end
		end
	end

	// Outputs only move on the rising edge, so compare mid cycle
	always @(negedge iSysClk)
	begin
		if (ack !== expAck)
			reportMismatch("ack", 32'(ack), 32'(expAck));
		if (err !== expErr)
			reportMismatch("err", 32'(err), 32'(expErr));
		if (datR !== expRd)
			reportMismatch("datR", datR, expRd);
		if (led !== ledM)
			reportMismatch("led", 32'(led), 32'(ledM));
	end

endmodule

`default_nettype wire

/* tbGpio.sv */
//------------------------------
// GPIO LED controller testbench
// LFSR driven Wishbone traffic, checked by gpioChecker
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module tbGpio;

	localparam int randLoops = 40;
	localparam int badLoops  = 20;   // Unmapped and misaligned each
	localparam int ledRun    = 40;
	localparam int b2bLoops  = 30;
	localparam int numAccess = 3*7 + 2*randLoops + 4*badLoops + 4*9 + b2bLoops;
	localparam int limitCycles = 2 * (10 + 3*numAccess + 4*3*ledRun);

	logic           iSysClk;
	logic           rstN;
	logic           cyc;
	logic           stb;
	logic           we;
	busPkg::wbAdrs  adr;
	busPkg::wbSel   sel;
	busPkg::wbData  datW;
	wire busPkg::wbData  datR;
	wire            ack;
	wire            err;
	wire gpioPkg::ledVec led;
	wire [31:0]     chkErrors;

	logic [15:0]    lfsr = 16'd30037;
	int             tbErrors = 0;
	logic [31:0]    r;
	logic [31:0]    r2;
	busPkg::wbAdrs  a;

	gpioTop dut
	(
		.iSysClk(iSysClk), .rstN(rstN),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel), .datW(datW),
		.datR(datR), .ack(ack), .err(err), .led(led)
	);

	gpioChecker uChecker
	(
		.iSysClk(iSysClk), .rstN(rstN),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel), .datW(datW),
		.datR(datR), .ack(ack), .err(err), .led(led), .errCount(chkErrors)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #2 iSysClk = ~iSysClk;   // 4 ns period
	end

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic getRand(input int nBits, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < nBits; k++)
		begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Register 0 EN, 1 MODE, 2 to 6 dividers
	function automatic busPkg::wbAdrs regAdrs(input int idx);
		logic [7:0] ofs;
		if (idx == 0)
			ofs = `GPIO_OFS_EN;
		else if (idx == 1)
			ofs = `GPIO_OFS_MODE;
		else
			ofs = `GPIO_OFS_IVT0 + 8'(`GPIO_OFS_STEP * (idx - 2));
		return {16'h0000, `GPIO_ADRS_MAP, ofs};
	endfunction

	//------------------------------
	// Wishbone master
	//------------------------------
	task automatic busAccess(input logic isWrite, input busPkg::wbAdrs ad,
		input busPkg::wbSel s, input busPkg::wbData d);
		int waitCnt;
		@(negedge iSysClk);
		cyc  = 1'b1;
		stb  = 1'b1;
		we   = isWrite;
		adr  = ad;
		sel  = s;
		datW = d;
		waitCnt = 0;
		do
		begin
			@(negedge iSysClk);
			waitCnt++;
		end
		while (!ack && !err && waitCnt < 8);
		if (!ack && !err)
		begin
			$display("No bus response at time %0t for address %h", $time, ad);
			tbErrors++;
		end
		cyc = 1'b0;   // Release the bus
		stb = 1'b0;
		we  = 1'b0;
	endtask

	// Read every register once
	task automatic readAllRegs();
		for (int i = 0; i < 7; i++)
			busAccess(1'b0, regAdrs(i), 4'hF, '0);
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(negedge iSysClk);
	endtask

	initial
	begin
		#(limitCycles * 4);
		$display("Watchdog timeout: tests did not finish within %0d cycles", limitCycles);
		$display("Errors: %0d mismatches, %0d bus failures", chkErrors, tbErrors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		rstN = 1'b0;
		cyc  = 1'b0;
		stb  = 1'b0;
		we   = 1'b0;
		adr  = '0;
		sel  = '0;
		datW = '0;
		repeat (5) @(posedge iSysClk);
		@(negedge iSysClk);
		rstN = 1'b1;

		// Reset values
		readAllRegs();

		// Byte masked writes with read back
		for (int n = 0; n < randLoops; n++)
		begin
			getRand(3, r);
			a = regAdrs(int'(r % 7));
			getRand(4, r);
			getRand(32, r2);
			busAccess(1'b1, a, busPkg::wbSel'(r[3:0]), r2);
			busAccess(1'b0, a, 4'hF, '0);
		end

		// Unmapped offsets and foreign blocks
		for (int n = 0; n < badLoops; n++)
		begin
			getRand(14, r);
			if (r[13])
				a = {16'h0000, `GPIO_ADRS_MAP, 8'h08 + {r[3:0], 2'b00}};   // 0x08 to 0x44
			else
				a = {16'h0000, (r[7:0] == `GPIO_ADRS_MAP) ? 8'h02 : r[7:0], 8'h00};
			if (a[7:0] >= 8'h1C && a[7:0] <= 8'h2C)
				a[7:0] = 8'h30;
			getRand(32, r2);
			busAccess(1'b1, a, 4'hF, r2);
			busAccess(1'b0, a, 4'hF, '0);
		end
		readAllRegs();   // Mapped registers untouched

		// Misaligned addresses
		for (int n = 0; n < badLoops; n++)
		begin
			getRand(5, r);
			a = regAdrs(int'(r[4:2] % 7)) | {30'd0, (r[1:0] == 2'b00) ? 2'b01 : r[1:0]};
			getRand(32, r2);
			busAccess(1'b1, a, 4'hF, r2);
			busAccess(1'b0, a, 4'hF, '0);
		end
		readAllRegs();

		// LED channels in each mode
		for (int m = 0; m < 4; m++)
		begin
			busAccess(1'b1, regAdrs(1), 4'hF, 32'(m));
			for (int i = 0; i < `GPIO_LED_NUM; i++)
			begin
				getRand(3, r);
				busAccess(1'b1, regAdrs(2 + i), 4'hF, r);
			end
			getRand(5, r);
			busAccess(1'b1, regAdrs(0), 4'hF, r);
			waitCycles(ledRun);
			getRand(3, r);
			getRand(3, r2);
			busAccess(1'b1, regAdrs(2 + int'(r % 5)), 4'h3, r2);   // Lands at next reload
			waitCycles(ledRun);
			getRand(5, r);
			busAccess(1'b1, regAdrs(0), 4'h1, r);
			waitCycles(ledRun);
		end

		// Back to back requests with one idle cycle between them
		for (int n = 0; n < b2bLoops; n++)
		begin
			getRand(4, r);
			getRand(32, r2);
			busAccess(r[3], regAdrs(int'(r[2:0] % 7)), 4'hF, r2);
		end

		waitCycles(2);
		@(posedge iSysClk);
		$display("Errors: %0d mismatches, %0d bus failures", chkErrors, tbErrors);
		if (chkErrors == 0 && tbErrors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
busPkg.sv
gpioPkg.sv
wbSlavePort.sv
gpioCsr.sv
ledChannel.sv
gpioTop.sv
gpioChecker.sv
tbGpio.sv

/* run.sh */
#!/bin/sh
# Build the GPIO testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tbGpio -f all.f -o simGpio > build.log 2>&1 &&
	./obj_dir/simGpio > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" ||
	{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
